// File: board_pkg.sv
package board_pkg;

    // player count and word widths
    localparam int NUM_PLAYERS = 4;
    localparam int KEY_PLAYERS = 3;
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int DIR_W       = 4;

    // buttons after the four directions, then start, coin and pause
    localparam int BUTTONS   = 2;
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    // game core expects active-low inputs
    localparam logic INPUTS_ACTIVE_LOW = 1'b1;

    typedef logic [BOARD_JOY_W-1:0] board_word_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;
    typedef logic [DIR_W-1:0]       dir_t;

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

    // core mode word from the OSD
    localparam int CORE_MOD_W = 7;
    localparam int EN4WAY_BIT = 1;

    // graphics layers
    localparam int NUM_GFX = 4;

    typedef logic [NUM_GFX-1:0] gfx_mask_t;

    // every layer enabled out of reset
    localparam gfx_mask_t GFX_EN_RESET = '1;

endpackage

// File: joy_if.sv
`timescale 1ns/1ps

interface joy_if import board_pkg::*; ();

    // synchronised board words, one per player
    board_word_t word [NUM_PLAYERS];

    // high once the sync stage runs out of reset
    logic valid;

    modport source (
        output word,
        output valid
    );

    modport sink (
        input word,
        input valid
    );

endinterface

// File: joy_4way.sv
`timescale 1ns/1ps

module joy_4way import board_pkg::*; (
    input  logic clk_sys,
    input  logic rst,
    input  logic enable,
    input  dir_t dir_in,
    output dir_t dir_out
);

    logic single_dir;

    // zero or one direction pressed
    assign single_dir = ((dir_in & (dir_in - 1'b1)) == '0);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out <= '0;
        end else if (!enable || single_dir) begin
            dir_out <= dir_in;
        end
        // diagonals keep the last single direction
    end

    // once clean under the filter, the output stays clean while it is on
    a_stays_4way : assert property (
        @(posedge clk_sys) disable iff (rst)
        $past(enable) && $onehot0($past(dir_out)) |-> $onehot0(dir_out)
    );

endmodule

// File: joy_sync.sv
`timescale 1ns/1ps

module joy_sync import board_pkg::*, ctrl_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic [CORE_MOD_W-1:0] core_mod,
    input  board_word_t           board_joystick [NUM_PLAYERS],
    joy_if.source                 joy
);

    logic en4way;
    dir_t dir_filt [NUM_PLAYERS];

    assign en4way = core_mod[EN4WAY_BIT];

    // one direction filter per player
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_filter
        joy_4way u_4way (
            .clk_sys (clk_sys),
            .rst     (rst),
            .enable  (en4way),
            .dir_in  (board_joystick[p][DIR_W-1:0]),
            .dir_out (dir_filt[p])
        );
    end

    // upper bits straight from the board, directions from the filter
    always_ff @(posedge clk_sys) begin
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            joy.word[p] <= {board_joystick[p][BOARD_JOY_W-1:DIR_W], dir_filt[p]};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy.valid <= 1'b0;
        end else begin
            joy.valid <= 1'b1;
        end
    end

endmodule

// File: joy_mapper.sv
`timescale 1ns/1ps

module joy_mapper import board_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst,
    joy_if.sink                    joy,
    input  game_joy_t              key_joy [KEY_PLAYERS],
    input  logic [NUM_PLAYERS-1:0] key_coin,
    input  logic [NUM_PLAYERS-1:0] key_start,
    input  logic                   rot_control,
    input  logic                   dip_flip,
    output game_joy_t              game_joystick [NUM_PLAYERS],
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start
);

    game_joy_t              merged [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] coin_joy;
    logic [NUM_PLAYERS-1:0] start_joy;

    // swap direction bits for vertical games
    function automatic game_joy_t apply_rotation(
        input game_joy_t joy_in,
        input logic      rot,
        input logic      flip
    );
        game_joy_t rotated;
        rotated = joy_in;
        if (rot) begin
            if (flip) begin
                rotated[DIR_W-1:0] = {joy_in[1], joy_in[0], joy_in[2], joy_in[3]};
            end else begin
                rotated[DIR_W-1:0] = {joy_in[0], joy_in[1], joy_in[3], joy_in[2]};
            end
        end
        return rotated;
    endfunction

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        // keyboard only covers the first players
        if (p < KEY_PLAYERS) begin : g_key
            assign merged[p] = joy.word[p][GAME_JOY_W-1:0] | key_joy[p];
        end else begin : g_board
            assign merged[p] = joy.word[p][GAME_JOY_W-1:0];
        end
        assign coin_joy[p]  = joy.word[p][COIN_BIT];
        assign start_joy[p] = joy.word[p][START_BIT];
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                game_joystick[p] <= '0;
            end
            game_coin  <= '0;
            game_start <= '0;
        end else if (joy.valid) begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                game_joystick[p] <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}}
                    ^ apply_rotation(merged[p], rot_control, !dip_flip);
            end
            // merged before inversion
            game_coin  <= {NUM_PLAYERS{INPUTS_ACTIVE_LOW}} ^ (coin_joy | key_coin);
            game_start <= {NUM_PLAYERS{INPUTS_ACTIVE_LOW}} ^ (start_joy | key_start);
        end
    end

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_chk
        a_joy_known : assert property (
            @(posedge clk_sys) disable iff (rst)
            joy.valid |=> !$isunknown({game_joystick[p], game_coin[p], game_start[p]})
        );
    end

endmodule

// File: board_ctrl.sv
`timescale 1ns/1ps

module board_ctrl import board_pkg::*, ctrl_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst,
    joy_if.sink       joy,
    input  logic      key_pause,
    input  logic      key_reset,
    input  logic      key_service,
    input  logic      osd_pause,
    input  logic      downloading,
    input  gfx_mask_t key_gfx,
    output logic      game_pause,
    output logic      soft_rst,
    output logic      game_service,
    output gfx_mask_t gfx_en
);

    logic      joy_pause;
    logic      last_key_pause;
    logic      last_joy_pause;
    logic      last_osd_pause;
    logic      last_key_reset;
    gfx_mask_t last_gfx;
    logic      pause_rise;
    logic      osd_change;

    // pause button on either of the first two sticks
    assign joy_pause = joy.word[0][PAUSE_BIT] | joy.word[1][PAUSE_BIT];

    assign pause_rise = (key_pause && !last_key_pause) || (joy_pause && !last_joy_pause);
    assign osd_change = osd_pause != last_osd_pause;

    // previous values for edge detection
    always_ff @(posedge clk_sys) begin
        last_key_pause <= key_pause;
        last_joy_pause <= joy_pause;
        last_osd_pause <= osd_pause;
        last_key_reset <= key_reset;
        last_gfx       <= key_gfx;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            gfx_en       <= GFX_EN_RESET;
            game_service <= INPUTS_ACTIVE_LOW;
        end else begin
            soft_rst <= key_reset && !last_key_reset;

            for (int i = 0; i < NUM_GFX; i++) begin
                if (key_gfx[i] && !last_gfx[i]) begin
                    gfx_en[i] <= !gfx_en[i];
                end
            end

            // download wins, then the OSD level, then a toggle
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                game_pause <= osd_pause;
            end else if (pause_rise) begin
                game_pause <= !game_pause;
            end

            game_service <= key_service ^ INPUTS_ACTIVE_LOW;
        end
    end

    a_soft_rst_pulse : assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    );

    a_download_unpause : assert property (
        @(posedge clk_sys) disable iff (rst)
        downloading |=> !game_pause
    );

endmodule

// File: game_inputs.sv
`timescale 1ns/1ps

module game_inputs import board_pkg::*, ctrl_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [CORE_MOD_W-1:0]  core_mod,
    input  board_word_t            board_joystick1,
    input  board_word_t            board_joystick2,
    input  board_word_t            board_joystick3,
    input  board_word_t            board_joystick4,
    input  game_joy_t              key_joy1,
    input  game_joy_t              key_joy2,
    input  game_joy_t              key_joy3,
    input  logic [NUM_PLAYERS-1:0] key_start,
    input  logic [NUM_PLAYERS-1:0] key_coin,
    input  logic                   key_pause,
    input  logic                   key_reset,
    input  logic                   key_service,
    input  logic                   osd_pause,
    input  logic                   downloading,
    input  logic                   rot_control,
    input  logic                   dip_flip,
    input  gfx_mask_t              key_gfx,
    output game_joy_t              game_joystick1,
    output game_joy_t              game_joystick2,
    output game_joy_t              game_joystick3,
    output game_joy_t              game_joystick4,
    output logic [NUM_PLAYERS-1:0] game_coin,
    output logic [NUM_PLAYERS-1:0] game_start,
    output logic                   game_pause,
    output logic                   soft_rst,
    output logic                   game_service,
    output gfx_mask_t              gfx_en
);

    board_word_t board_joy [NUM_PLAYERS];
    game_joy_t   key_joy   [KEY_PLAYERS];
    game_joy_t   game_joy  [NUM_PLAYERS];

    // flat ports to player arrays
    assign board_joy[0] = board_joystick1;
    assign board_joy[1] = board_joystick2;
    assign board_joy[2] = board_joystick3;
    assign board_joy[3] = board_joystick4;

    assign key_joy[0] = key_joy1;
    assign key_joy[1] = key_joy2;
    assign key_joy[2] = key_joy3;

    assign game_joystick1 = game_joy[0];
    assign game_joystick2 = game_joy[1];
    assign game_joystick3 = game_joy[2];
    assign game_joystick4 = game_joy[3];

    joy_if u_joy ();

    joy_sync u_sync (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .core_mod       (core_mod),
        .board_joystick (board_joy),
        .joy            (u_joy.source)
    );

    joy_mapper u_mapper (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .joy           (u_joy.sink),
        .key_joy       (key_joy),
        .key_coin      (key_coin),
        .key_start     (key_start),
        .rot_control   (rot_control),
        .dip_flip      (dip_flip),
        .game_joystick (game_joy),
        .game_coin     (game_coin),
        .game_start    (game_start)
    );

    board_ctrl u_ctrl (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .joy          (u_joy.sink),
        .key_pause    (key_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .osd_pause    (osd_pause),
        .downloading  (downloading),
        .key_gfx      (key_gfx),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .game_service (game_service),
        .gfx_en       (gfx_en)
    );

endmodule

// File: tb_game_inputs.sv
`timescale 1ns/1ps

module tb_game_inputs import board_pkg::*, ctrl_pkg::*; ();

    localparam int HOLD_CYCLES    = 6;
    localparam int RESET_CYCLES   = 8;
    localparam int N_4WAY         = 12;
    localparam int N_ROT          = 32;
    localparam int N_CTRL         = 14;
    localparam int N_MIX          = 40;
    localparam int N_VECTORS      = N_4WAY + N_ROT + N_CTRL + N_MIX;
    localparam int TIMEOUT_CYCLES = N_VECTORS * HOLD_CYCLES + RESET_CYCLES + 100;

    // singles and diagonals with the filter on for the first eight
    localparam dir_t DIR_SEQ [N_4WAY] = '{
        4'b0001, 4'b0011, 4'b0010, 4'b0110, 4'b0000, 4'b1001,
        4'b1000, 4'b1100, 4'b0011, 4'b0101, 4'b1010, 4'b1111
    };

    logic                   clk_sys = 1'b0;
    logic                   rst;
    logic [CORE_MOD_W-1:0]  core_mod;
    board_word_t            board_joy [NUM_PLAYERS];
    game_joy_t              key_joy [KEY_PLAYERS];
    logic [NUM_PLAYERS-1:0] key_start;
    logic [NUM_PLAYERS-1:0] key_coin;
    logic                   key_pause;
    logic                   key_reset;
    logic                   key_service;
    logic                   osd_pause;
    logic                   downloading;
    logic                   rot_control;
    logic                   dip_flip;
    gfx_mask_t              key_gfx;
    game_joy_t              game_joy [NUM_PLAYERS];
    logic [NUM_PLAYERS-1:0] game_coin;
    logic [NUM_PLAYERS-1:0] game_start;
    logic                   game_pause;
    logic                   soft_rst;
    logic                   game_service;
    gfx_mask_t              gfx_en;

    // next vector staged before it is driven
    logic [CORE_MOD_W-1:0]  nx_core_mod;
    board_word_t            nx_board [NUM_PLAYERS];
    game_joy_t              nx_key_joy [KEY_PLAYERS];
    logic [NUM_PLAYERS-1:0] nx_key_start;
    logic [NUM_PLAYERS-1:0] nx_key_coin;
    logic                   nx_key_pause;
    logic                   nx_key_reset;
    logic                   nx_key_service;
    logic                   nx_osd;
    logic                   nx_downloading;
    logic                   nx_rot;
    logic                   nx_flip;
    gfx_mask_t              nx_key_gfx;

    // expected direction held by each 4-way filter
    dir_t filt_dir [NUM_PLAYERS];

    // board control model
    logic      sync_pause;
    logic      prev_key_pause;
    logic      prev_joy_pause;
    logic      prev_osd;
    logic      prev_key_reset;
    gfx_mask_t prev_gfx;
    logic      exp_pause;
    logic      exp_soft;
    logic      exp_service;
    gfx_mask_t exp_gfx;
    int        cycle_count = 0;

    game_inputs dut0 (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .core_mod        (core_mod),
        .board_joystick1 (board_joy[0]),
        .board_joystick2 (board_joy[1]),
        .board_joystick3 (board_joy[2]),
        .board_joystick4 (board_joy[3]),
        .key_joy1        (key_joy[0]),
        .key_joy2        (key_joy[1]),
        .key_joy3        (key_joy[2]),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_pause       (key_pause),
        .key_reset       (key_reset),
        .key_service     (key_service),
        .osd_pause       (osd_pause),
        .downloading     (downloading),
        .rot_control     (rot_control),
        .dip_flip        (dip_flip),
        .key_gfx         (key_gfx),
        .game_joystick1  (game_joy[0]),
        .game_joystick2  (game_joy[1]),
        .game_joystick3  (game_joy[2]),
        .game_joystick4  (game_joy[3]),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_pause      (game_pause),
        .soft_rst        (soft_rst),
        .game_service    (game_service),
        .gfx_en          (gfx_en)
    );

    always #2 clk_sys = ~clk_sys;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // merge keys, rotate the direction field, then invert for the core
    function automatic game_joy_t expected_joystick(input board_word_t synced,
                                                    input game_joy_t key, input logic rot,
                                                    input logic flip_dip);
        game_joy_t merged;
        game_joy_t result;
        int        src [DIR_W];
        merged = synced[GAME_JOY_W-1:0] | key;
        result = merged;
        if (rot) begin
            // source bit for output bits 0 to 3
            if (!flip_dip) begin
                src = '{3, 2, 0, 1};
            end else begin
                src = '{2, 3, 1, 0};
            end
            for (int b = 0; b < DIR_W; b++) begin
                result[b] = merged[src[b]];
            end
        end
        return result ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
    endfunction

    function automatic logic expected_button(input logic joy_bit, input logic key_bit);
        return INPUTS_ACTIVE_LOW ^ (joy_bit | key_bit);
    endfunction

    task automatic random_stimulus();
        nx_core_mod = CORE_MOD_W'($urandom);
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            nx_board[p] = board_word_t'($urandom);
        end
        for (int k = 0; k < KEY_PLAYERS; k++) begin
            nx_key_joy[k] = game_joy_t'($urandom & $urandom);
        end
        nx_key_start   = NUM_PLAYERS'($urandom);
        nx_key_coin    = NUM_PLAYERS'($urandom);
        nx_key_pause   = 1'($urandom);
        nx_key_reset   = 1'($urandom);
        nx_key_service = 1'($urandom);
        nx_osd         = 1'($urandom);
        nx_downloading = ($urandom % 8) == 0;
        nx_rot         = 1'($urandom);
        nx_flip        = 1'($urandom);
        nx_key_gfx     = gfx_mask_t'($urandom);
    endtask

    // random game bits, no pause bits, control keys released, osd level kept
    task automatic quiet_stimulus();
        random_stimulus();
        nx_osd = osd_pause;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            nx_board[p][PAUSE_BIT] = 1'b0;
        end
        nx_key_pause   = 1'b0;
        nx_key_reset   = 1'b0;
        nx_downloading = 1'b0;
        nx_key_gfx     = '0;
    endtask

    task automatic check_reset_values();
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            check_value($sformatf("game_joystick%0d", p + 1), game_joy[p], '0);
        end
        check_value("game_coin", game_coin, '0);
        check_value("game_start", game_start, '0);
        check_value("game_pause", game_pause, 1'b0);
        check_value("soft_rst", soft_rst, 1'b0);
        check_value("gfx_en", gfx_en, GFX_EN_RESET);
        check_value("game_service", game_service, INPUTS_ACTIVE_LOW);
    endtask

    task automatic check_outputs();
        board_word_t            synced;
        game_joy_t              key_part;
        logic [NUM_PLAYERS-1:0] exp_coin;
        logic [NUM_PLAYERS-1:0] exp_start;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            synced   = {nx_board[p][BOARD_JOY_W-1:DIR_W], filt_dir[p]};
            key_part = '0;
            if (p < KEY_PLAYERS) begin
                key_part = nx_key_joy[p];
            end
            check_value($sformatf("game_joystick%0d", p + 1), game_joy[p],
                        expected_joystick(synced, key_part, nx_rot, nx_flip));
            exp_coin[p]  = expected_button(nx_board[p][COIN_BIT], nx_key_coin[p]);
            exp_start[p] = expected_button(nx_board[p][START_BIT], nx_key_start[p]);
        end
        check_value("game_coin", game_coin, exp_coin);
        check_value("game_start", game_start, exp_start);
    endtask

    task automatic apply_and_check();
        dir_t d;
        @(posedge clk_sys);
        core_mod     <= nx_core_mod;
        board_joy[0] <= nx_board[0];
        board_joy[1] <= nx_board[1];
        board_joy[2] <= nx_board[2];
        board_joy[3] <= nx_board[3];
        key_joy[0]   <= nx_key_joy[0];
        key_joy[1]   <= nx_key_joy[1];
        key_joy[2]   <= nx_key_joy[2];
        key_start    <= nx_key_start;
        key_coin     <= nx_key_coin;
        key_pause    <= nx_key_pause;
        key_reset    <= nx_key_reset;
        key_service  <= nx_key_service;
        osd_pause    <= nx_osd;
        downloading  <= nx_downloading;
        rot_control  <= nx_rot;
        dip_flip     <= nx_flip;
        key_gfx      <= nx_key_gfx;
        // a diagonal under the 4-way rule leaves the last direction in place
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            d = nx_board[p][DIR_W-1:0];
            if (!nx_core_mod[EN4WAY_BIT] || $countones(d) <= 1) begin
                filt_dir[p] = d;
            end
        end
        repeat (HOLD_CYCLES - 1) @(posedge clk_sys);
        @(negedge clk_sys);
        check_outputs();
    endtask

    // joystick pause passes the sync register before edge detection
    always @(posedge clk_sys) begin
        sync_pause     <= board_joy[0][PAUSE_BIT] | board_joy[1][PAUSE_BIT];
        prev_key_pause <= key_pause;
        prev_joy_pause <= sync_pause;
        prev_osd       <= osd_pause;
        prev_key_reset <= key_reset;
        prev_gfx       <= key_gfx;
        if (rst) begin
            exp_pause   <= 1'b0;
            exp_soft    <= 1'b0;
            exp_gfx     <= GFX_EN_RESET;
            exp_service <= INPUTS_ACTIVE_LOW;
        end else begin
            exp_soft    <= key_reset & ~prev_key_reset;
            exp_gfx     <= exp_gfx ^ (key_gfx & ~prev_gfx);
            exp_service <= key_service ^ INPUTS_ACTIVE_LOW;
            if (downloading) begin
                exp_pause <= 1'b0;
            end else if (osd_pause != prev_osd) begin
                exp_pause <= osd_pause;
            end else if ((key_pause & ~prev_key_pause) | (sync_pause & ~prev_joy_pause)) begin
                exp_pause <= ~exp_pause;
            end
        end
    end

    always @(negedge clk_sys) begin
        if (!rst) begin
            check_value("game_pause", game_pause, exp_pause);
            check_value("soft_rst", soft_rst, exp_soft);
            check_value("gfx_en", gfx_en, exp_gfx);
            check_value("game_service", game_service, exp_service);
        end
    end

    always @(posedge clk_sys) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: the run timed out after %0d cycles", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(57));
        rst         = 1'b1;
        core_mod    = '0;
        key_start   = '0;
        key_coin    = '0;
        key_pause   = 1'b0;
        key_reset   = 1'b0;
        key_service = 1'b0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
        rot_control = 1'b0;
        dip_flip    = 1'b0;
        key_gfx     = '0;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            board_joy[p] = '0;
            filt_dir[p]  = '0;
        end
        for (int k = 0; k < KEY_PLAYERS; k++) begin
            key_joy[k] = '0;
        end

        repeat (RESET_CYCLES - 1) @(posedge clk_sys);
        @(negedge clk_sys);
        check_reset_values();
        @(posedge clk_sys);
        rst <= 1'b0;
        @(negedge clk_sys);
        check_reset_values();

        // 4-way filter on, then off
        for (int i = 0; i < N_4WAY; i++) begin
            quiet_stimulus();
            nx_rot = 1'b0;
            nx_core_mod[EN4WAY_BIT] = (i < 8);
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                nx_board[p][DIR_W-1:0] = DIR_SEQ[i];
            end
            apply_and_check();
        end

        // every rot_control and dip_flip pair
        for (int i = 0; i < N_ROT; i++) begin
            random_stimulus();
            nx_rot  = i[1];
            nx_flip = i[0];
            apply_and_check();
        end

        // directed pause, soft reset and graphics steps
        for (int i = 0; i < N_CTRL; i++) begin
            quiet_stimulus();
            case (i)
                1: nx_key_pause = 1'b1;
                2: nx_board[1][PAUSE_BIT] = 1'b1;
                4: nx_osd = !osd_pause;
                5: nx_key_pause = 1'b1;
                6: begin
                    nx_osd = !osd_pause;
                    nx_board[0][PAUSE_BIT] = 1'b1;
                end
                7: begin
                    nx_downloading = 1'b1;
                    nx_key_pause = 1'b1;
                end
                9: nx_key_reset = 1'b1;
                10: nx_key_gfx = 4'b0001;
                11: nx_key_gfx = 4'b0011;
                12: nx_key_gfx = 4'b0100;
                13: nx_key_gfx = 4'b1111;
                default: ;
            endcase
            apply_and_check();
        end

        for (int i = 0; i < N_MIX; i++) begin
            random_stimulus();
            apply_and_check();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// File: verilog.f
board_pkg.sv
ctrl_pkg.sv
joy_if.sv
joy_4way.sv
joy_sync.sv
joy_mapper.sv
board_ctrl.sv
game_inputs.sv
tb_game_inputs.sv

// File: Bender.yml
package:
  name: game_inputs

sources:
  - files:
      - board_pkg.sv
      - ctrl_pkg.sv
      - joy_if.sv
      - joy_4way.sv
      - joy_sync.sv
      - joy_mapper.sv
      - board_ctrl.sv
      - game_inputs.sv
  - target: test
    files:
      - tb_game_inputs.sv
